/* verilog/eq_pkg.sv */
package eq_pkg;

    // Input sample width, signed two's complement
    localparam int DATA_WIDTH = 8;

    // Coefficient width, signed two's complement
    localparam int COEFF_WIDTH = 8;

    // Taps per filter, the current sample included
    localparam int TAP_COUNT = 4;

    // Filter result width
    // Three guard bits cover the growth of a four-term sum
    localparam int FIR_WIDTH = DATA_WIDTH + COEFF_WIDTH + 3;

    // Unsigned band gain in quarter steps, 0 to 3.75
    localparam int GAIN_WIDTH = 4;

    // Shift that removes the quarter-step scale of the gains
    localparam int GAIN_SHIFT = 2;

    // Saturated equalizer output width
    localparam int OUT_WIDTH = 12;

    // Coefficient sets are packed with tap 0 in the most significant slice,
    // so each literal below reads from tap 0 to tap 3

    // Low-pass 1, 2, 2, 1 (DC gain of 6)
    localparam logic [TAP_COUNT*COEFF_WIDTH-1:0] LOW_COEFFS = {
        COEFF_WIDTH'(1),
        COEFF_WIDTH'(2),
        COEFF_WIDTH'(2),
        COEFF_WIDTH'(1)
    };

    // High-pass 1, -3, 3, -1
    // Taps sum to zero so a constant input settles to zero
    localparam logic [TAP_COUNT*COEFF_WIDTH-1:0] HIGH_COEFFS = {
        COEFF_WIDTH'(1),
        COEFF_WIDTH'(-3),
        COEFF_WIDTH'(3),
        COEFF_WIDTH'(-1)
    };

endpackage

/* verilog/fir_filter.sv */
`timescale 1ns/1ps

module fir_filter
    import eq_pkg::*;
#(
    parameter int DATA_WIDTH  = eq_pkg::DATA_WIDTH,
    parameter int COEFF_WIDTH = eq_pkg::COEFF_WIDTH,
    parameter int TAP_COUNT   = eq_pkg::TAP_COUNT,
    parameter int FIR_WIDTH   = eq_pkg::FIR_WIDTH,
    // Tap 0 sits in the most significant slice
    parameter logic [TAP_COUNT*COEFF_WIDTH-1:0] COEFFS = LOW_COEFFS
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic signed [DATA_WIDTH-1:0] in_sample,
    input  logic                         in_valid,
    output logic signed [FIR_WIDTH-1:0]  result,
    output logic                         out_valid
);

    // Past samples, history[0] is the one before the current sample
    logic signed [DATA_WIDTH-1:0] history [TAP_COUNT-1];

    // Sample seen by each tap, tap 0 is the incoming sample
    logic signed [DATA_WIDTH-1:0] tap_sample [TAP_COUNT];

    // Unpacked coefficients
    logic signed [COEFF_WIDTH-1:0] coeff [TAP_COUNT];

    // Per-tap products at full result width
    logic signed [FIR_WIDTH-1:0] prod [TAP_COUNT];

    // Combinational multiply-accumulate
    logic signed [FIR_WIDTH-1:0] acc;

    // Slice the packed coefficient set
    for (genvar i = 0; i < TAP_COUNT; i++) begin : g_coeff
        assign coeff[i] = COEFFS[(TAP_COUNT-1-i)*COEFF_WIDTH +: COEFF_WIDTH];
    end

    // The new sample feeds tap 0 directly so the result includes it
    assign tap_sample[0] = in_sample;

    for (genvar i = 1; i < TAP_COUNT; i++) begin : g_tap
        assign tap_sample[i] = history[i-1];
    end

    // Products are sign extended to FIR_WIDTH before the multiply
    always_comb begin
        for (int i = 0; i < TAP_COUNT; i++) begin
            prod[i] = tap_sample[i] * coeff[i];
        end
    end

    always_comb begin
        acc = '0;
        for (int i = 0; i < TAP_COUNT; i++) begin
            acc = acc + prod[i];
        end
    end

    // Delay line update
    // Only a valid sample moves the line, gaps leave it untouched
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < TAP_COUNT-1; k++) begin
                history[k] <= '0;
            end
        end else if (in_valid) begin
            history[0] <= in_sample;
            for (int k = 1; k < TAP_COUNT-1; k++) begin
                history[k] <= history[k-1];
            end
        end
    end

    // Registered result, held between valid samples
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (in_valid) begin
            result <= acc;
        end
    end

    // One pulse per accepted sample, one cycle behind it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule

/* verilog/band_mixer.sv */
`timescale 1ns/1ps

module band_mixer
    import eq_pkg::*;
#(
    parameter int FIR_WIDTH  = eq_pkg::FIR_WIDTH,
    parameter int GAIN_WIDTH = eq_pkg::GAIN_WIDTH,
    parameter int GAIN_SHIFT = eq_pkg::GAIN_SHIFT,
    parameter int OUT_WIDTH  = eq_pkg::OUT_WIDTH
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic signed [FIR_WIDTH-1:0] low_band,
    input  logic signed [FIR_WIDTH-1:0] high_band,
    input  logic                        in_valid,
    input  logic [GAIN_WIDTH-1:0]       gain_low,
    input  logic [GAIN_WIDTH-1:0]       gain_high,
    output logic signed [OUT_WIDTH-1:0] mix_out,
    output logic                        out_valid
);

    // Gain gets one zero bit on top so it multiplies as a positive signed value
    localparam int PROD_WIDTH = FIR_WIDTH + GAIN_WIDTH + 1;

    // One more bit for the sum of two products
    localparam int SUM_WIDTH = PROD_WIDTH + 1;

    // Output range limits at sum width
    localparam logic signed [SUM_WIDTH-1:0] OUT_MAX =
        {{(SUM_WIDTH-OUT_WIDTH+1){1'b0}}, {(OUT_WIDTH-1){1'b1}}};
    localparam logic signed [SUM_WIDTH-1:0] OUT_MIN =
        {{(SUM_WIDTH-OUT_WIDTH+1){1'b1}}, {(OUT_WIDTH-1){1'b0}}};

    logic signed [GAIN_WIDTH:0]     gain_low_s;
    logic signed [GAIN_WIDTH:0]     gain_high_s;
    logic signed [PROD_WIDTH-1:0]   low_prod;
    logic signed [PROD_WIDTH-1:0]   high_prod;
    logic signed [SUM_WIDTH-1:0]    sum;
    logic signed [SUM_WIDTH-1:0]    scaled;
    logic signed [OUT_WIDTH-1:0]    clamped;

    assign gain_low_s  = $signed({1'b0, gain_low});
    assign gain_high_s = $signed({1'b0, gain_high});

    // Weighted band sum
    always_comb begin
        low_prod  = low_band * gain_low_s;
        high_prod = high_band * gain_high_s;
        sum       = low_prod + high_prod;
    end

    // Arithmetic shift, rounds toward minus infinity
    assign scaled = sum >>> GAIN_SHIFT;

    // Clamp to the signed output range
    always_comb begin
        if (scaled > OUT_MAX) begin
            clamped = OUT_MAX[OUT_WIDTH-1:0];
        end else if (scaled < OUT_MIN) begin
            clamped = OUT_MIN[OUT_WIDTH-1:0];
        end else begin
            clamped = scaled[OUT_WIDTH-1:0];
        end
    end

    // Output register, updated only on a valid band pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mix_out <= '0;
        end else if (in_valid) begin
            mix_out <= clamped;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule

/* verilog/two_band_eq.sv */
`timescale 1ns/1ps

module two_band_eq
    import eq_pkg::*;
#(
    parameter int DATA_WIDTH  = eq_pkg::DATA_WIDTH,
    parameter int COEFF_WIDTH = eq_pkg::COEFF_WIDTH,
    parameter int TAP_COUNT   = eq_pkg::TAP_COUNT,
    parameter int FIR_WIDTH   = eq_pkg::FIR_WIDTH,
    parameter int GAIN_WIDTH  = eq_pkg::GAIN_WIDTH,
    parameter int GAIN_SHIFT  = eq_pkg::GAIN_SHIFT,
    parameter int OUT_WIDTH   = eq_pkg::OUT_WIDTH,
    parameter logic [TAP_COUNT*COEFF_WIDTH-1:0] LOW_COEFFS  = eq_pkg::LOW_COEFFS,
    parameter logic [TAP_COUNT*COEFF_WIDTH-1:0] HIGH_COEFFS = eq_pkg::HIGH_COEFFS
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic signed [DATA_WIDTH-1:0] sample,
    input  logic                         sample_valid,
    input  logic [GAIN_WIDTH-1:0]        gain_low,
    input  logic [GAIN_WIDTH-1:0]        gain_high,
    output logic signed [OUT_WIDTH-1:0]  eq_out,
    output logic                         eq_out_valid
);

    // Band results, one cycle after the sample
    logic signed [FIR_WIDTH-1:0] low_band;
    logic signed [FIR_WIDTH-1:0] high_band;
    logic                        low_valid;

    // Same timing as low_valid
    // Only the bound assertions look at it
    logic                        high_valid;

    // Low band
    fir_filter #(
        .DATA_WIDTH  (DATA_WIDTH),
        .COEFF_WIDTH (COEFF_WIDTH),
        .TAP_COUNT   (TAP_COUNT),
        .FIR_WIDTH   (FIR_WIDTH),
        .COEFFS      (LOW_COEFFS)
    ) u_low (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_sample (sample),
        .in_valid  (sample_valid),
        .result    (low_band),
        .out_valid (low_valid)
    );

    // High band, fed from the same sample stream
    fir_filter #(
        .DATA_WIDTH  (DATA_WIDTH),
        .COEFF_WIDTH (COEFF_WIDTH),
        .TAP_COUNT   (TAP_COUNT),
        .FIR_WIDTH   (FIR_WIDTH),
        .COEFFS      (HIGH_COEFFS)
    ) u_high (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_sample (sample),
        .in_valid  (sample_valid),
        .result    (high_band),
        .out_valid (high_valid)
    );

    // Gain, sum and saturate, adds the second cycle of latency
    band_mixer #(
        .FIR_WIDTH  (FIR_WIDTH),
        .GAIN_WIDTH (GAIN_WIDTH),
        .GAIN_SHIFT (GAIN_SHIFT),
        .OUT_WIDTH  (OUT_WIDTH)
    ) u_mixer (
        .clk       (clk),
        .rst_n     (rst_n),
        .low_band  (low_band),
        .high_band (high_band),
        .in_valid  (low_valid),
        .gain_low  (gain_low),
        .gain_high (gain_high),
        .mix_out   (eq_out),
        .out_valid (eq_out_valid)
    );

endmodule

/* test/eq_sva.sv */
`timescale 1ns/1ps

module eq_sva (
    input logic clk,
    input logic rst_n,
    input logic sample_valid,
    input logic low_valid,
    input logic high_valid,
    input logic eq_out_valid
);

    // Count of failed assertions
    int fail_count = 0;

    // Both filters see the same strobe
    a_band_valids: assert property (@(posedge clk) low_valid == high_valid)
        else begin
            $error("Band valids differ, low %0b high %0b", low_valid, high_valid);
            fail_count++;
        end

    // Two cycles from an accepted sample to its output
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        eq_out_valid == $past(sample_valid && rst_n, 2))
        else begin
            $error("eq_out_valid does not follow sample_valid by two cycles");
            fail_count++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !low_valid && !high_valid && !eq_out_valid)
        else begin
            $error("A valid is high while reset is held");
            fail_count++;
        end

endmodule

bind two_band_eq eq_sva u_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .low_valid    (low_valid),
    .high_valid   (high_valid),
    .eq_out_valid (eq_out_valid)
);

/* test/eq_checker.sv */
`timescale 1ns/1ps

module eq_checker
    import eq_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic signed [DATA_WIDTH-1:0] sample,
    input  logic                         sample_valid,
    input  logic [GAIN_WIDTH-1:0]        gain_low,
    input  logic [GAIN_WIDTH-1:0]        gain_high,
    input  logic signed [OUT_WIDTH-1:0]  eq_out,
    input  logic                         eq_out_valid
);

    // Tap weights, tap 0 first
    int low_coeff [TAP_COUNT] = '{1, 2, 2, 1};
    int high_coeff [TAP_COUNT] = '{1, -3, 3, -1};

    // Last valid samples, newest at index 0
    int history [TAP_COUNT];

    // Band results waiting for the gains of the next cycle
    bit band_pending;
    int low_band;
    int high_band;

    // Predicted outputs in arrival order
    int expected_q [$];

    int    error_count = 0;
    int    check_count = 0;
    string test_name = "reset";

    // Weighted sum, floor shift, then clamp to the output range
    function automatic int predict(input int low, input int high, input int gl, input int gh);
        int total;
        int limit;
        limit = 1 << (OUT_WIDTH - 1);
        total = (low * gl + high * gh) >>> GAIN_SHIFT;
        if (total > limit - 1) begin
            total = limit - 1;
        end else if (total < -limit) begin
            total = -limit;
        end
        return total;
    endfunction

    always @(posedge clk) begin : compare
        int exp_value;
        if (!rst_n) begin
            for (int i = 0; i < TAP_COUNT; i++) begin
                history[i] = 0;
            end
            expected_q.delete();
            band_pending = 1'b0;
        end else begin
            if (eq_out_valid) begin
                if (expected_q.size() == 0) begin
                    $display("Output valid in test %s with no sample waiting for it", test_name);
                    error_count++;
                end else begin
                    exp_value = expected_q.pop_front();
                    check_count++;
                    if (int'(eq_out) != exp_value) begin
                        $display("error: %s expected %0d actual %0d",
                                 test_name, exp_value, eq_out);
                        error_count++;
                    end
                end
            end
            // Gains count one cycle after the sample
            if (band_pending) begin
                expected_q.push_back(predict(low_band, high_band,
                                             int'(gain_low), int'(gain_high)));
                band_pending = 1'b0;
            end
            if (sample_valid) begin
                for (int i = TAP_COUNT - 1; i > 0; i--) begin
                    history[i] = history[i-1];
                end
                history[0] = int'(sample);
                low_band   = 0;
                high_band  = 0;
                for (int i = 0; i < TAP_COUNT; i++) begin
                    low_band  += low_coeff[i] * history[i];
                    high_band += high_coeff[i] * history[i];
                end
                band_pending = 1'b1;
            end
        end
    end

endmodule

/* test/tb_two_band_eq.sv */
`timescale 1ns/1ps

module tb_two_band_eq
    import eq_pkg::*;
();

    // Valid samples over all tests, sets the watchdog limit
    localparam int TOTAL_SAMPLES = 5 + 6 + 300 + 16 + 80;

    logic                         clk;
    logic                         rst_n;
    logic signed [DATA_WIDTH-1:0] sample;
    logic                         sample_valid;
    logic [GAIN_WIDTH-1:0]        gain_low;
    logic [GAIN_WIDTH-1:0]        gain_high;
    logic signed [OUT_WIDTH-1:0]  eq_out;
    logic                         eq_out_valid;

    integer seed = 32'hfb5a;

    two_band_eq DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .gain_low     (gain_low),
        .gain_high    (gain_high),
        .eq_out       (eq_out),
        .eq_out_valid (eq_out_valid)
    );

    eq_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .gain_low     (gain_low),
        .gain_high    (gain_high),
        .eq_out       (eq_out),
        .eq_out_valid (eq_out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : watchdog
        #((TOTAL_SAMPLES * 4 + 50) * 20);
        $display("Timeout: the run did not finish in the time allowed");
        $display("Some tests failed");
        $finish;
    end

    task automatic send(input int value);
        @(posedge clk);
        sample       <= value[DATA_WIDTH-1:0];
        sample_valid <= 1'b1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            sample_valid <= 1'b0;
        end
    endtask

    // Takes effect on the edge the caller last waited for
    task automatic set_gains(input int gl, input int gh);
        gain_low  <= gl[GAIN_WIDTH-1:0];
        gain_high <= gh[GAIN_WIDTH-1:0];
    endtask

    task automatic start_test(input string name);
        u_checker.test_name = name;
    endtask

    // About one gap in four, gap_mask widens the gaps
    task automatic random_stream(input int count, input int gap_mask, input bit change_gains);
        int sent;
        int gl;
        int gh;
        sent = 0;
        while (sent < count) begin
            if (($random(seed) & 3) == 0) begin
                idle(1 + ($random(seed) & gap_mask));
            end else begin
                send($random(seed));
                sent++;
            end
            if (change_gains && (($random(seed) & 7) == 0)) begin
                gl = $random(seed) & 15;
                gh = $random(seed) & 15;
                set_gains(gl, gh);
            end
        end
    endtask

    // Reset in the middle of a stream, the samples offered meanwhile are dropped
    task automatic pulse_reset();
        @(posedge clk);
        rst_n        <= 1'b0;
        sample       <= DATA_WIDTH'($random(seed));
        sample_valid <= 1'b1;
        @(posedge clk);
        sample       <= DATA_WIDTH'($random(seed));
        @(posedge clk);
        rst_n        <= 1'b1;
        sample_valid <= 1'b0;
    endtask

    initial begin : stimulus
        int errors;
        rst_n        = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        gain_low     = '0;
        gain_high    = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        start_test("lowpass_impulse");
        set_gains(4, 0);
        send(100);
        repeat (4) send(0);
        idle(4);

        start_test("highpass_constant");
        set_gains(0, 4);
        repeat (6) send(50);
        idle(4);

        start_test("random_mix");
        random_stream(300, 0, 1'b1);
        idle(4);

        start_test("saturation");
        set_gains(15, 15);
        repeat (8) begin
            send(127);
            send(-128);
        end
        idle(4);

        start_test("gaps_and_reset");
        random_stream(40, 3, 1'b1);
        pulse_reset();
        random_stream(40, 3, 1'b0);
        idle(6);

        errors = u_checker.error_count;
        if (DUT.u_sva.fail_count != 0) begin
            $display("%0d assertion failures were seen", DUT.u_sva.fail_count);
            errors += DUT.u_sva.fail_count;
        end
        if (u_checker.expected_q.size() != 0) begin
            $display("%0d predicted outputs never appeared", u_checker.expected_q.size());
            errors++;
        end
        if (u_checker.check_count == 0) begin
            $display("No output sample was checked");
            errors++;
        end
        $display("Checks: %0d, errors: %0d", u_checker.check_count, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sources.f */
verilog/eq_pkg.sv
verilog/fir_filter.sv
verilog/band_mixer.sv
verilog/two_band_eq.sv
test/eq_sva.sv
test/eq_checker.sv
test/tb_two_band_eq.sv

/* Makefile */
TOP = tb_two_band_eq

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into sim.log, report PASS or FAIL"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Some tests failed" sim.log || ! grep -q "All tests passed" sim.log; then \
		echo "FAIL"; \
		exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf obj_dir sim.log
